//--- vlog.f
commit_pkg.sv
commit_buffer_if.sv
commit_buffer.sv
commit_arbiter.sv
forward_select.sv
commit_stage.sv
tb_commit_stage.sv

//--- Bender.yml
package:
  name: commit_stage

sources:
  - commit_pkg.sv
  - commit_buffer_if.sv
  - commit_buffer.sv
  - commit_arbiter.sv
  - forward_select.sv
  - commit_stage.sv
  - target: test
    files:
      - tb_commit_stage.sv

//--- tb_commit_stage.sv
/*
 * Self-checking testbench of the commit stage. A table of per-cycle stimulus
 * and expected values is applied in a loop, and a per-port scoreboard checks
 * every reorder buffer write against the results that were sent.
 */
module tb_commit_stage import commit_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 29;
    localparam int DRAIN_CYCLES = 4 * BUFFER_DEPTH;

    // One cycle of stimulus plus what the DUT must show in that cycle.
    // A forward source value of -1 means no forward, otherwise 2*row+port
    typedef struct packed {
        logic [NUM_PORTS-1:0]        valid;
        reg_addr_t [NUM_PORTS-1:0]   dest;
        logic                        stall;
        logic                        flush;
        reg_addr_t [NUM_FWD_SRC-1:0] src;
        logic                        exp_write;
        logic                        exp_stall;
        logic                        exp_empty;
        int                          fwd0;
        int                          fwd1;
    } row_t;

    // Scoreboard entry of a result that still waits for its commit
    typedef struct packed {
        data_word_t result;
        reg_addr_t  dest;
        rob_tag_t   tag;
    } entry_t;

    logic                         clk;
    logic                         rst_n;
    logic                         flush;
    logic                         stall;
    logic [NUM_PORTS-1:0]         valid;
    data_word_t [NUM_PORTS-1:0]   result;
    reg_addr_t [NUM_PORTS-1:0]    dest;
    rob_tag_t [NUM_PORTS-1:0]     tag;
    logic                         rob_write;
    data_word_t                   rob_result;
    reg_addr_t                    rob_dest;
    rob_tag_t                     rob_tag;
    logic                         stall_out;
    logic                         buffers_empty;
    reg_addr_t [NUM_FWD_SRC-1:0]  fwd_src;
    data_word_t [NUM_FWD_SRC-1:0] fwd_data;
    logic [NUM_FWD_SRC-1:0]       fwd_valid;

    row_t       rows [NUM_ROWS];
    int         row_count;
    data_word_t sent [2 * NUM_ROWS];
    entry_t     pending [NUM_PORTS][$];
    integer     seed;
    int         value_errors;
    int         other_errors;

    commit_stage #(.BUFFER_DEPTH(BUFFER_DEPTH)) dut_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush),
        .stall_i         (stall),
        .valid_i         (valid),
        .result_i        (result),
        .dest_i          (dest),
        .tag_i           (tag),
        .rob_write_o     (rob_write),
        .rob_result_o    (rob_result),
        .rob_dest_o      (rob_dest),
        .rob_tag_o       (rob_tag),
        .stall_o         (stall_out),
        .buffers_empty_o (buffers_empty),
        .fwd_src_i       (fwd_src),
        .fwd_data_o      (fwd_data),
        .fwd_valid_o     (fwd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic check_word(string name, data_word_t got, data_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_dest(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    // ======================================================================
    // Table, driving and scoreboard
    // ======================================================================

    task automatic add_row(logic [1:0] v, reg_addr_t d_itu, reg_addr_t d_lsu, logic [1:0] ctl,
                           reg_addr_t s0, reg_addr_t s1, logic [2:0] exp, int f0, int f1);
        rows[row_count].valid     = v;
        rows[row_count].dest      = {d_lsu, d_itu};
        rows[row_count].stall     = ctl[1];
        rows[row_count].flush     = ctl[0];
        rows[row_count].src       = {s1, s0};
        rows[row_count].exp_write = exp[2];
        rows[row_count].exp_stall = exp[1];
        rows[row_count].exp_empty = exp[0];
        rows[row_count].fwd0      = f0;
        rows[row_count].fwd1      = f1;
        row_count++;
    endtask

    task automatic drive_row(int r);
        for (int p = 0; p < NUM_PORTS; p++) begin
            valid[p]        = rows[r].valid[p];
            dest[p]         = rows[r].dest[p];
            tag[p]          = rob_tag_t'(2 * r + p);
            result[p]       = $random(seed);
            sent[2 * r + p] = result[p];
        end
        stall   = rows[r].stall;
        flush   = rows[r].flush;
        fwd_src = rows[r].src;
    endtask

    // Record this cycle's inputs, then match a commit against a queue head
    task automatic score_cycle();
        entry_t e;
        int     hit;

        hit = -1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (flush) begin
                pending[p].delete();
            end else if (valid[p]) begin
                e.result = result[p];
                e.dest   = dest[p];
                e.tag    = tag[p];
                pending[p].push_back(e);
            end
        end
        if (rob_write) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (hit < 0 && pending[p].size() > 0 && pending[p][0].result == rob_result) begin
                    hit = p;
                end
            end
            if (hit < 0) begin
                other_errors++;
                $display("Commit of result %h at %0t is not the oldest pending result of any port",
                         rob_result, $time);
            end else begin
                e = pending[hit].pop_front();
                check_dest("rob_dest_o", rob_dest, e.dest);
                check_tag("rob_tag_o", rob_tag, e.tag);
            end
        end
    endtask

    task automatic check_row(int r);
        int from;

        check_bit($sformatf("row %0d rob_write_o", r), rob_write, rows[r].exp_write);
        check_bit($sformatf("row %0d stall_o", r), stall_out, rows[r].exp_stall);
        check_bit($sformatf("row %0d buffers_empty_o", r), buffers_empty, rows[r].exp_empty);
        for (int s = 0; s < NUM_FWD_SRC; s++) begin
            from = (s == 0) ? rows[r].fwd0 : rows[r].fwd1;
            check_bit($sformatf("row %0d fwd_valid_o[%0d]", r, s), fwd_valid[s], from >= 0);
            if (from >= 0) begin
                check_word($sformatf("row %0d fwd_data_o[%0d]", r, s), fwd_data[s], sent[from]);
            end
        end
    endtask

    task automatic build_table();
        // valid {lsu,itu}, dest itu, dest lsu, {stall,flush}, src0, src1,
        // expected {write,stall_o,empty}, forward source of src0 and src1
        add_row(2'b01,  3,  0, 2'b00,  3,  0, 3'b101,  0, -1);
        add_row(2'b10,  0,  4, 2'b00,  4,  3, 3'b101,  3, -1);
        add_row(2'b11,  5,  6, 2'b00,  5,  6, 3'b101,  4,  5);
        add_row(2'b00,  0,  0, 2'b00,  6,  0, 3'b000,  5, -1);
        add_row(2'b00,  0,  0, 2'b00,  6,  0, 3'b100,  5, -1);
        add_row(2'b11,  7,  8, 2'b00,  8,  7, 3'b101, 11, 10);
        add_row(2'b11,  9, 10, 2'b00,  7,  9, 3'b100, 10, 12);
        add_row(2'b11,  7, 11, 2'b00,  7,  9, 3'b100, 14, 12);
        add_row(2'b00,  0,  0, 2'b00,  7, 11, 3'b100, 14, 15);
        add_row(2'b00,  0,  0, 2'b00,  7,  0, 3'b100, 14, -1);
        add_row(2'b00,  0,  0, 2'b00,  0,  0, 3'b100, -1, -1);
        // Register 13 is buffered, then overwritten so the copy goes stale
        add_row(2'b11, 12, 13, 2'b00, 13,  0, 3'b101, 23, -1);
        add_row(2'b01, 13,  0, 2'b00, 13,  0, 3'b100, 24, -1);
        add_row(2'b00,  0,  0, 2'b10, 13,  0, 3'b000, -1, -1);
        // Fill the LSU buffer under stall until stall_o rises
        add_row(2'b10,  0, 14, 2'b10,  0,  0, 3'b000, -1, -1);
        add_row(2'b10,  0, 15, 2'b10,  0,  0, 3'b000, -1, -1);
        add_row(2'b10,  0, 16, 2'b10,  0,  0, 3'b000, -1, -1);
        add_row(2'b00,  0,  0, 2'b10, 16,  0, 3'b010, 33, -1);
        add_row(2'b00,  0,  0, 2'b00,  0,  0, 3'b110, -1, -1);
        add_row(2'b00,  0,  0, 2'b00,  0,  0, 3'b100, -1, -1);
        add_row(2'b01,  0,  0, 2'b00,  0, 15, 3'b100, -1, 31);
        // Flush drops both buffers and the result arriving with it
        add_row(2'b10,  0, 17, 2'b01, 17,  0, 3'b000, 43, -1);
        add_row(2'b00,  0,  0, 2'b00, 16,  0, 3'b001, -1, -1);
        add_row(2'b11, 18, 19, 2'b00, 19, 18, 3'b101, 47, 46);
        add_row(2'b01, 20,  0, 2'b00, 20, 19, 3'b100, 48, 47);
        add_row(2'b11, 21, 21, 2'b00, 21,  0, 3'b100, 50, -1);
        add_row(2'b00,  0,  0, 2'b00, 21,  0, 3'b100, 50, -1);
        add_row(2'b00,  0,  0, 2'b00, 21,  0, 3'b100, 50, -1);
        add_row(2'b00,  0,  0, 2'b00,  0,  0, 3'b001, -1, -1);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        seed         = 32'hfd22_2e94;
        value_errors = 0;
        other_errors = 0;
        row_count    = 0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        stall        = 1'b0;
        valid        = '0;
        result       = '0;
        dest         = '0;
        tag          = '0;
        // Nonzero sources, so a buffer that kept an entry through reset would forward it
        fwd_src      = {reg_addr_t'(2), reg_addr_t'(1)};
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_bit("rob_write_o after reset", rob_write, 1'b0);
        check_bit("stall_o after reset", stall_out, 1'b0);
        check_bit("buffers_empty_o after reset", buffers_empty, 1'b1);
        check_bit("fwd_valid_o[0] after reset", fwd_valid[0], 1'b0);
        check_bit("fwd_valid_o[1] after reset", fwd_valid[1], 1'b0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_row(r);
            @(negedge clk);
            score_cycle();
            check_row(r);
            @(posedge clk);
            #1;
        end

        valid   = '0;
        stall   = 1'b0;
        flush   = 1'b0;
        fwd_src = '0;
        while (!buffers_empty || pending[PORT_ITU].size() != 0 || pending[PORT_LSU].size() != 0) begin
            @(negedge clk);
            score_cycle();
            @(posedge clk);
            #1;
        end

        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + NUM_ROWS + DRAIN_CYCLES + 4) * CLK_PERIOD);
        $display("Watchdog expired with results still pending in the scoreboard");
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
        $display("Regression failed");
        $finish;
    end

endmodule : tb_commit_stage

//--- commit_stage.sv
/*
 * Commit stage between the ITU and LSU execution ports and the reorder
 * buffer. Each port has its own commit buffer, a round-robin arbiter writes
 * one result per cycle, and operands are forwarded from ports and buffers.
 */
module commit_stage import commit_pkg::*; #(
    parameter int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  logic                            stall_i,

    input  logic [NUM_PORTS-1:0]            valid_i,
    input  data_word_t [NUM_PORTS-1:0]      result_i,
    input  reg_addr_t [NUM_PORTS-1:0]       dest_i,
    input  rob_tag_t [NUM_PORTS-1:0]        tag_i,

    output logic                            rob_write_o,
    output data_word_t                      rob_result_o,
    output reg_addr_t                       rob_dest_o,
    output rob_tag_t                        rob_tag_o,

    output logic                            stall_o,
    output logic                            buffers_empty_o,

    input  reg_addr_t [NUM_FWD_SRC-1:0]     fwd_src_i,
    output data_word_t [NUM_FWD_SRC-1:0]    fwd_data_o,
    output logic [NUM_FWD_SRC-1:0]          fwd_valid_o
);

    // Forwarding candidates from each buffer
    data_word_t [NUM_PORTS-1:0][NUM_FWD_SRC-1:0] buf_fwd_data;
    logic [NUM_PORTS-1:0][NUM_FWD_SRC-1:0]       buf_fwd_hit;

    commit_buffer_if #(.BUFFER_DEPTH(BUFFER_DEPTH)) itu_bus ();
    commit_buffer_if #(.BUFFER_DEPTH(BUFFER_DEPTH)) lsu_bus ();

    // ======================================================================
    // Commit buffers
    // ======================================================================

    commit_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) itu_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .wr_result_i  (result_i[PORT_ITU]),
        .wr_dest_i    (dest_i[PORT_ITU]),
        .wr_tag_i     (tag_i[PORT_ITU]),
        .kill_valid_i (valid_i),
        .kill_dest_i  (dest_i),
        .fwd_src_i    (fwd_src_i),
        .fwd_data_o   (buf_fwd_data[PORT_ITU]),
        .fwd_hit_o    (buf_fwd_hit[PORT_ITU]),
        .bus          (itu_bus.buffer)
    );

    commit_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) lsu_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .wr_result_i  (result_i[PORT_LSU]),
        .wr_dest_i    (dest_i[PORT_LSU]),
        .wr_tag_i     (tag_i[PORT_LSU]),
        .kill_valid_i (valid_i),
        .kill_dest_i  (dest_i),
        .fwd_src_i    (fwd_src_i),
        .fwd_data_o   (buf_fwd_data[PORT_LSU]),
        .fwd_hit_o    (buf_fwd_hit[PORT_LSU]),
        .bus          (lsu_bus.buffer)
    );

    // ======================================================================
    // Arbiter and forwarding
    // ======================================================================

    commit_arbiter arbiter (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .stall_i         (stall_i),
        .valid_i         (valid_i),
        .result_i        (result_i),
        .dest_i          (dest_i),
        .tag_i           (tag_i),
        .bus_itu         (itu_bus.arbiter),
        .bus_lsu         (lsu_bus.arbiter),
        .rob_write_o     (rob_write_o),
        .rob_result_o    (rob_result_o),
        .rob_dest_o      (rob_dest_o),
        .rob_tag_o       (rob_tag_o),
        .stall_o         (stall_o),
        .buffers_empty_o (buffers_empty_o)
    );

    forward_select fwd_select (
        .valid_i     (valid_i),
        .result_i    (result_i),
        .dest_i      (dest_i),
        .fwd_src_i   (fwd_src_i),
        .buf_data_i  (buf_fwd_data),
        .buf_hit_i   (buf_fwd_hit),
        .fwd_data_o  (fwd_data_o),
        .fwd_valid_o (fwd_valid_o)
    );

endmodule : commit_stage

//--- forward_select.sv
/*
 * Picks the forwarded value of each register source operand. Incoming
 * port results win over buffered ones, and the ITU wins over the LSU.
 */
module forward_select import commit_pkg::*; (
    input  logic [NUM_PORTS-1:0]                        valid_i,
    input  data_word_t [NUM_PORTS-1:0]                  result_i,
    input  reg_addr_t [NUM_PORTS-1:0]                   dest_i,

    input  reg_addr_t [NUM_FWD_SRC-1:0]                 fwd_src_i,

    // Candidates found by each commit buffer
    input  data_word_t [NUM_PORTS-1:0][NUM_FWD_SRC-1:0] buf_data_i,
    input  logic [NUM_PORTS-1:0][NUM_FWD_SRC-1:0]       buf_hit_i,

    output data_word_t [NUM_FWD_SRC-1:0]                fwd_data_o,
    output logic [NUM_FWD_SRC-1:0]                      fwd_valid_o
);

    // Sources are checked from lowest to highest priority so that the last
    // match written is the one that counts
    always_comb begin
        for (int s = 0; s < NUM_FWD_SRC; s++) begin
            fwd_valid_o[s] = 1'b0;
            fwd_data_o[s]  = '0;

            // Register 0 reads as zero and is never forwarded
            if (fwd_src_i[s] != '0) begin
                // Buffered entries, LSU buffer first so the ITU buffer overrides
                for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                    if (buf_hit_i[p][s]) begin
                        fwd_valid_o[s] = 1'b1;
                        fwd_data_o[s]  = buf_data_i[p][s];
                    end
                end

                // Results arriving this cycle are newer than anything buffered
                for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                    if (valid_i[p] && dest_i[p] == fwd_src_i[s]) begin
                        fwd_valid_o[s] = 1'b1;
                        fwd_data_o[s]  = result_i[p];
                    end
                end
            end
        end
    end

endmodule : forward_select

//--- commit_arbiter.sv
/*
 * Round-robin arbiter of the commit stage. Each cycle it commits at most
 * one result, either the head of the buffer on turn or a bypassed input,
 * and pushes every other valid input into its port's buffer.
 */
module commit_arbiter import commit_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        stall_i,

    // Results from the execution ports
    input  logic [NUM_PORTS-1:0]        valid_i,
    input  data_word_t [NUM_PORTS-1:0]  result_i,
    input  reg_addr_t [NUM_PORTS-1:0]   dest_i,
    input  rob_tag_t [NUM_PORTS-1:0]    tag_i,

    commit_buffer_if.arbiter            bus_itu,
    commit_buffer_if.arbiter            bus_lsu,

    // Reorder buffer write port
    output logic                        rob_write_o,
    output data_word_t                  rob_result_o,
    output reg_addr_t                   rob_dest_o,
    output rob_tag_t                    rob_tag_o,

    output logic                        stall_o,
    output logic                        buffers_empty_o
);

    arb_state_t state_q, state_d;

    logic [NUM_PORTS-1:0]       buf_full;
    logic [NUM_PORTS-1:0]       buf_empty;
    logic [NUM_PORTS-1:0]       push;
    logic [NUM_PORTS-1:0]       pop;
    data_word_t [NUM_PORTS-1:0] head_result;
    reg_addr_t [NUM_PORTS-1:0]  head_dest;
    rob_tag_t [NUM_PORTS-1:0]   head_tag;

    // Port on turn, the other port, and the input picked for a bypass
    logic own;
    logic other;
    logic byp_port;

    // ======================================================================
    // Buffer links gathered into per-port arrays
    // ======================================================================

    assign buf_full[PORT_ITU]    = bus_itu.full;
    assign buf_full[PORT_LSU]    = bus_lsu.full;
    assign buf_empty[PORT_ITU]   = bus_itu.empty;
    assign buf_empty[PORT_LSU]   = bus_lsu.empty;
    assign head_result[PORT_ITU] = bus_itu.head_result;
    assign head_result[PORT_LSU] = bus_lsu.head_result;
    assign head_dest[PORT_ITU]   = bus_itu.head_dest;
    assign head_dest[PORT_LSU]   = bus_lsu.head_dest;
    assign head_tag[PORT_ITU]    = bus_itu.head_tag;
    assign head_tag[PORT_LSU]    = bus_lsu.head_tag;

    assign bus_itu.push = push[PORT_ITU];
    assign bus_lsu.push = push[PORT_LSU];
    assign bus_itu.pop  = pop[PORT_ITU];
    assign bus_lsu.pop  = pop[PORT_LSU];

    // ======================================================================
    // Turn selection and commit
    // ======================================================================

    assign own      = (state_q == ARB_LSU) ? 1'(PORT_LSU) : 1'(PORT_ITU);
    assign other    = ~own;
    // The port on turn gets the bypass first
    assign byp_port = valid_i[own] ? own : other;

    always_comb begin
        state_d      = state_q;
        push         = '0;
        pop          = '0;
        rob_write_o  = 1'b0;
        rob_result_o = '0;
        rob_dest_o   = '0;
        rob_tag_o    = '0;

        // A flush throws away the buffers and whatever arrives with it
        if (!flush_i) begin
            // By default every valid result waits in its own buffer
            push = valid_i;

            if (!stall_i) begin
                if (!buf_empty[own]) begin
                    pop[own]     = 1'b1;
                    rob_write_o  = 1'b1;
                    rob_result_o = head_result[own];
                    rob_dest_o   = head_dest[own];
                    rob_tag_o    = head_tag[own];
                end else if (|valid_i) begin
                    // Nothing is queued on this turn, commit a fresh result
                    push[byp_port] = 1'b0;
                    rob_write_o    = 1'b1;
                    rob_result_o   = result_i[byp_port];
                    rob_dest_o     = dest_i[byp_port];
                    rob_tag_o      = tag_i[byp_port];
                end
            end

            // Hand the turn over only when the other buffer has work
            if (!buf_empty[other]) begin
                state_d = (state_q == ARB_ITU) ? ARB_LSU : ARB_ITU;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= ARB_ITU;
        end else if (!stall_i && !stall_o) begin
            state_q <= state_d;
        end
    end

    assign stall_o         = |buf_full;
    assign buffers_empty_o = &buf_empty;

    a_no_write_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !rob_write_o && !bus_itu.pop && !bus_lsu.pop);

endmodule : commit_arbiter

//--- commit_buffer.sv
/*
 * Circular FIFO that holds finished results of one execution port until
 * the arbiter commits them. It also marks entries stale when a newer write
 * to the same register shows up and serves operand forwarding lookups.
 */
module commit_buffer import commit_pkg::*; #(
    parameter int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // Result presented by this buffer's execution port
    input  data_word_t                          wr_result_i,
    input  reg_addr_t                           wr_dest_i,
    input  rob_tag_t                            wr_tag_i,

    // Incoming writes of every port, used to retire older copies
    input  logic [NUM_PORTS-1:0]                kill_valid_i,
    input  reg_addr_t [NUM_PORTS-1:0]           kill_dest_i,

    // Forwarding lookup
    input  reg_addr_t [NUM_FWD_SRC-1:0]         fwd_src_i,
    output data_word_t [NUM_FWD_SRC-1:0]        fwd_data_o,
    output logic [NUM_FWD_SRC-1:0]              fwd_hit_o,

    commit_buffer_if.buffer                     bus
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    // ======================================================================
    // Storage
    // ======================================================================

    data_word_t [BUFFER_DEPTH-1:0] result_q;
    reg_addr_t [BUFFER_DEPTH-1:0]  dest_q;
    rob_tag_t [BUFFER_DEPTH-1:0]   tag_q;

    // An entry is live while it may still be forwarded
    logic [BUFFER_DEPTH-1:0]       live_q;

    ptr_t   rd_ptr_q;
    ptr_t   wr_ptr_q;
    count_t count_q;

    // Payload is only written on push and read behind the count
    always_ff @(posedge clk_i) begin
        if (bus.push) begin
            result_q[wr_ptr_q] <= wr_result_i;
            dest_q[wr_ptr_q]   <= wr_dest_i;
            tag_q[wr_ptr_q]    <= wr_tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            live_q   <= '0;
        end else begin
            // A fresh write to register d makes every held copy of d stale
            for (int i = 0; i < BUFFER_DEPTH; i++) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (kill_valid_i[p] && kill_dest_i[p] != '0 && dest_q[i] == kill_dest_i[p]) begin
                        live_q[i] <= 1'b0;
                    end
                end
            end

            // The entry being pushed is the newest copy and stays live
            if (bus.push) begin
                live_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end

            if (bus.pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            unique case ({bus.push, bus.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ======================================================================
    // Status and head
    // ======================================================================

    assign bus.full        = (count_q == count_t'(BUFFER_DEPTH));
    assign bus.empty       = (count_q == '0);
    assign bus.head_result = result_q[rd_ptr_q];
    assign bus.head_dest   = dest_q[rd_ptr_q];
    assign bus.head_tag    = tag_q[rd_ptr_q];

    // ======================================================================
    // Forwarding search
    // ======================================================================

    // Walk from oldest to newest so the newest live match is the one kept
    always_comb begin
        ptr_t idx;

        for (int s = 0; s < NUM_FWD_SRC; s++) begin
            fwd_hit_o[s]  = 1'b0;
            fwd_data_o[s] = '0;
            for (int k = 0; k < BUFFER_DEPTH; k++) begin
                idx = rd_ptr_q + ptr_t'(k);
                if (k < count_q && live_q[idx] && dest_q[idx] == fwd_src_i[s]) begin
                    fwd_hit_o[s]  = 1'b1;
                    fwd_data_o[s] = result_q[idx];
                end
            end
        end
    end

    // The arbiter only pushes into a full buffer when it drains it too
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.push && bus.full |-> bus.pop);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.pop |-> !bus.empty);

endmodule : commit_buffer

//--- commit_buffer_if.sv
/*
 * Link between one commit buffer and the round-robin arbiter.
 * The arbiter drives push and pop, the buffer reports its status and head.
 */
interface commit_buffer_if import commit_pkg::*; #(
    parameter int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH
) ();

    // Pointers wrap by plain overflow, so the depth has to be a power of two
    if (BUFFER_DEPTH < 2 || (BUFFER_DEPTH & (BUFFER_DEPTH - 1)) != 0) begin : g_depth_check
        $error("commit buffer depth must be a power of two of at least 2");
    end

    // Push stores the port's incoming result, pop drops the oldest entry
    logic push;
    logic pop;

    // Occupancy flags
    logic full;
    logic empty;

    // Oldest entry, valid whenever empty is low
    data_word_t head_result;
    reg_addr_t  head_dest;
    rob_tag_t   head_tag;

    modport buffer  (input push, pop, output full, empty, head_result, head_dest, head_tag);
    modport arbiter (output push, pop, input full, empty, head_result, head_dest, head_tag);

endinterface : commit_buffer_if

//--- commit_pkg.sv
/*
 * Widths, port indices and arbiter state shared by the commit stage.
 * The RTL modules and the testbench import it with a wildcard import.
 */
package commit_pkg;

    // ======================================================================
    // Data widths
    // ======================================================================

    // Result word that an execution unit hands to the reorder buffer
    typedef logic [31:0] data_word_t;

    // Architectural register index, register 0 is hardwired to zero
    // and therefore never forwards
    typedef logic [4:0] reg_addr_t;

    // Slot index inside the reorder buffer
    typedef logic [5:0] rob_tag_t;

    // ======================================================================
    // Execution ports and forwarding operands
    // ======================================================================

    // Integer unit with fixed latency and load/store unit with variable
    // latency, each with its own commit buffer
    localparam int NUM_PORTS = 2;
    localparam int PORT_ITU  = 0;
    localparam int PORT_LSU  = 1;

    // Two register source operands are looked up every cycle
    localparam int NUM_FWD_SRC = 2;

    // Entries per commit buffer unless the top level overrides it
    localparam int DEFAULT_BUFFER_DEPTH = 4;

    // ======================================================================
    // Arbiter
    // ======================================================================

    // Whose turn it is to drain its buffer into the reorder buffer
    typedef enum logic {
        ARB_ITU,
        ARB_LSU
    } arb_state_t;

endpackage : commit_pkg
